// File: hw/axi_word_ram.sv
`timescale 1ns/1ps

module axi_word_ram (
  input  logic                               clk,
  input  logic                               rst,
  // write address and data
  input  logic [mem_mmio_pkg::ram_addr_w-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [mem_mmio_pkg::data_w-1:0]     wdata,
  input  logic [mem_mmio_pkg::data_w/8-1:0]   wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  // write response
  output logic                               bvalid,
  input  logic                               bready,
  // read address
  input  logic [mem_mmio_pkg::ram_addr_w-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  // read data
  output logic [mem_mmio_pkg::data_w-1:0]     rdata,
  output logic                               rvalid,
  input  logic                               rready
);
  import mem_mmio_pkg::*;

  logic [data_w-1:0] mem [ram_words];

  logic wr_acc, rd_acc;
  logic bvalid_q, rvalid_q;
  logic [data_w-1:0] rdata_q;
  logic [ram_addr_w-3:0] wr_idx, rd_idx;

  // the word index leaves out the two byte offset bits
  assign wr_idx = awaddr[ram_addr_w-1:2];
  assign rd_idx = araddr[ram_addr_w-1:2];

  ////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////
  // aw and w are taken together in one cycle
  assign wr_acc  = awvalid && wvalid && !bvalid_q;
  assign awready = wr_acc;
  assign wready  = wr_acc;

  assign rd_acc  = arvalid && !rvalid_q;
  assign arready = rd_acc;

  assign bvalid = bvalid_q;
  assign rvalid = rvalid_q;
  assign rdata  = rdata_q;

  ////////////////////////////////////////////////////////////
  // response state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_acc)
        bvalid_q <= 1'b1;
      else if (bready)
        bvalid_q <= 1'b0;

      if (rd_acc)
        rvalid_q <= 1'b1;
      else if (rready)
        rvalid_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      for (int b = 0; b < data_w/8; b++) begin
        if (wstrb[b])
          mem[wr_idx][b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc)
      rdata_q <= mem[rd_idx];  // only loaded on a new request
  end

  a_rdata_hold: assert property (@(posedge clk) disable iff (!rst)
    rvalid && !rready |=> $stable(rdata))
    else $error("rdata changed while waiting for rready");

endmodule

// File: hw/mem_mmio_pkg.sv
package mem_mmio_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////
  localparam int data_w = 32;
  localparam int addr_w = 32;

  ////////////////////////////////////////////////////////////
  // ram sizing
  ////////////////////////////////////////////////////////////
  localparam int mem_kb     = 4;
  localparam int ram_addr_w = $clog2(mem_kb * 1024);  // byte address inside the ram
  localparam int ram_words  = (mem_kb * 1024) / 4;

  ////////////////////////////////////////////////////////////
  // memory mapped registers
  ////////////////////////////////////////////////////////////
  localparam logic [addr_w-1:0] mmio_print_addr  = 32'hA000_0000;  // write only, uart byte
  localparam logic [addr_w-1:0] mmio_status_addr = 32'hA000_0004;  // read only, uart busy
  localparam logic [addr_w-1:0] mmio_csr_addr    = 32'hA000_0008;  // write only, csr port

  // kept small so a whole frame fits in a short simulation
  localparam int clocks_per_baud = 8;

  ////////////////////////////////////////////////////////////
  // axi response codes
  ////////////////////////////////////////////////////////////
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

// File: hw/mmio_ctrl.sv
`timescale 1ns/1ps

module mmio_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  // external axi port
  input  logic [mem_mmio_pkg::addr_w-1:0] awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [mem_mmio_pkg::data_w-1:0] wdata,
  input  logic [mem_mmio_pkg::data_w/8-1:0] wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  logic [mem_mmio_pkg::addr_w-1:0] araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [mem_mmio_pkg::data_w-1:0] rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready,
  // ram side
  output logic [mem_mmio_pkg::ram_addr_w-1:0] ram_awaddr,
  output logic                           ram_awvalid,
  input  logic                           ram_awready,
  output logic [mem_mmio_pkg::data_w-1:0] ram_wdata,
  output logic [mem_mmio_pkg::data_w/8-1:0] ram_wstrb,
  output logic                           ram_wvalid,
  input  logic                           ram_wready,
  input  logic                           ram_bvalid,
  output logic                           ram_bready,
  output logic [mem_mmio_pkg::ram_addr_w-1:0] ram_araddr,
  output logic                           ram_arvalid,
  input  logic                           ram_arready,
  input  logic [mem_mmio_pkg::data_w-1:0] ram_rdata,
  input  logic                           ram_rvalid,
  output logic                           ram_rready,
  // uart and csr
  output logic                           uart_wr,
  output logic [7:0]                     uart_data,
  input  logic                           uart_busy,
  output logic [7:0]                     csr
);
  import mem_mmio_pkg::*;

  logic aw_print, aw_csr, aw_mmio, ar_status;
  logic pend_print_q, pend_csr_q, w_pend;
  logic mmio_bvalid_q, mmio_rvalid_q;
  logic status_busy_q;
  logic ram_wr_open;
  logic mmio_aw_acc, mmio_w_acc, status_acc;
  logic [7:0] csr_q;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////
  assign aw_print  = (awaddr == mmio_print_addr);
  assign aw_csr    = (awaddr == mmio_csr_addr);
  assign aw_mmio   = aw_print || aw_csr;
  assign ar_status = (araddr == mmio_status_addr);

  assign w_pend = pend_print_q || pend_csr_q;  // an mmio aw is waiting for its data beat

  ////////////////////////////////////////////////////////////
  // write path
  ////////////////////////////////////////////////////////////
  // the ram only sees a write while no mmio write is in flight
  assign ram_wr_open = !w_pend && !mmio_bvalid_q;

  assign mmio_aw_acc = awvalid && aw_mmio && !w_pend && !mmio_bvalid_q && !ram_bvalid;
  assign mmio_w_acc  = wvalid && w_pend;

  assign ram_awaddr  = awaddr[ram_addr_w-1:0];  // upper bits dropped, so addresses alias
  assign ram_awvalid = awvalid && !aw_mmio && ram_wr_open;
  assign ram_wdata   = wdata;
  assign ram_wstrb   = wstrb;
  assign ram_wvalid  = wvalid && ram_wr_open && !(awvalid && aw_mmio);
  assign ram_bready  = bready;

  assign awready = mmio_aw_acc || ram_awready;
  assign wready  = mmio_w_acc || ram_wready;
  assign bvalid  = mmio_bvalid_q || ram_bvalid;
  assign bresp   = resp_okay;

  assign uart_wr   = mmio_w_acc && pend_print_q;
  assign uart_data = wdata[7:0];
  assign csr       = csr_q;

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////
  assign status_acc  = arvalid && ar_status && !mmio_rvalid_q && !ram_rvalid;
  assign ram_araddr  = araddr[ram_addr_w-1:0];
  assign ram_arvalid = arvalid && !ar_status && !mmio_rvalid_q;
  assign ram_rready  = rready;

  assign arready = status_acc || ram_arready;
  assign rvalid  = mmio_rvalid_q || ram_rvalid;
  assign rdata   = mmio_rvalid_q ? {{(data_w-1){1'b0}}, status_busy_q} : ram_rdata;
  assign rresp   = resp_okay;

  always_ff @(posedge clk) begin
    if (!rst) begin
      pend_print_q  <= 1'b0;
      pend_csr_q    <= 1'b0;
      mmio_bvalid_q <= 1'b0;
      mmio_rvalid_q <= 1'b0;
      csr_q         <= 8'h00;
    end else begin
      if (mmio_aw_acc) begin
        pend_print_q <= aw_print;
        pend_csr_q   <= aw_csr;
      end else if (mmio_w_acc) begin
        pend_print_q <= 1'b0;
        pend_csr_q   <= 1'b0;
      end

      if (mmio_w_acc && pend_csr_q)
        csr_q <= wdata[7:0];

      if (mmio_w_acc)
        mmio_bvalid_q <= 1'b1;
      else if (bready)
        mmio_bvalid_q <= 1'b0;

      if (status_acc)
        mmio_rvalid_q <= 1'b1;
      else if (rready)
        mmio_rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (status_acc)
      status_busy_q <= uart_busy;  // held for the whole response
  end

  // a print byte only leaves with a data beat that the ram does not also take
  a_uart_wr_needs_wready: assert property (@(posedge clk) disable iff (!rst)
    uart_wr |-> wready && !ram_wready)
    else $error("uart_wr high without wready, or the ram took the same data beat");

  a_single_bvalid: assert property (@(posedge clk) disable iff (!rst)
    !(ram_bvalid && mmio_bvalid_q))
    else $error("ram and mmio write responses overlap");

endmodule

// File: hw/soc_mem_mmio_top.sv
`timescale 1ns/1ps

module soc_mem_mmio_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [mem_mmio_pkg::addr_w-1:0]   awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [mem_mmio_pkg::data_w-1:0]   wdata,
  input  logic [mem_mmio_pkg::data_w/8-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [mem_mmio_pkg::addr_w-1:0]   araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [mem_mmio_pkg::data_w-1:0]   rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  output logic [7:0]                        csr,
  output logic                              uart_tx
);
  import mem_mmio_pkg::*;

  // ram channels after the mmio cut
  logic [ram_addr_w-1:0] ram_awaddr, ram_araddr;
  logic                  ram_awvalid, ram_awready;
  logic [data_w-1:0]     ram_wdata, ram_rdata;
  logic [data_w/8-1:0]   ram_wstrb;
  logic                  ram_wvalid, ram_wready;
  logic                  ram_bvalid, ram_bready;
  logic                  ram_arvalid, ram_arready;
  logic                  ram_rvalid, ram_rready;

  logic       uart_wr, uart_busy;
  logic [7:0] uart_data;

  mmio_ctrl u_ctrl (
    .clk, .rst,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .ram_awaddr, .ram_awvalid, .ram_awready,
    .ram_wdata, .ram_wstrb, .ram_wvalid, .ram_wready,
    .ram_bvalid, .ram_bready,
    .ram_araddr, .ram_arvalid, .ram_arready,
    .ram_rdata, .ram_rvalid, .ram_rready,
    .uart_wr, .uart_data, .uart_busy,
    .csr
  );

  axi_word_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (ram_awaddr),
    .awvalid (ram_awvalid),
    .awready (ram_awready),
    .wdata   (ram_wdata),
    .wstrb   (ram_wstrb),
    .wvalid  (ram_wvalid),
    .wready  (ram_wready),
    .bvalid  (ram_bvalid),
    .bready  (ram_bready),
    .araddr  (ram_araddr),
    .arvalid (ram_arvalid),
    .arready (ram_arready),
    .rdata   (ram_rdata),
    .rvalid  (ram_rvalid),
    .rready  (ram_rready)
  );

  uart_tx_lite u_uart (
    .clk  (clk),
    .rst  (rst),
    .wr   (uart_wr),
    .data (uart_data),
    .tx   (uart_tx),
    .busy (uart_busy)
  );

endmodule

// File: hw/uart_tx_lite.sv
`timescale 1ns/1ps

module uart_tx_lite (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr,
  input  logic [7:0] data,
  output logic       tx,
  output logic       busy
);
  import mem_mmio_pkg::*;

  localparam int baud_w = $clog2(clocks_per_baud);

  logic [baud_w-1:0] baud_cnt;
  logic [3:0]        bit_cnt;   // 0 is the start bit, 9 the stop bit
  logic [8:0]        shreg;     // data bits then the stop bit
  logic              tx_q;
  logic              busy_q;
  logic              bit_end;

  assign bit_end = (baud_cnt == baud_w'(clocks_per_baud - 1));

  assign tx   = tx_q;
  assign busy = busy_q;

  ////////////////////////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst) begin
      busy_q   <= 1'b0;
      tx_q     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!busy_q) begin
      if (wr) begin               // a write while busy is dropped
        busy_q   <= 1'b1;
        tx_q     <= 1'b0;         // start bit
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (bit_end) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy_q <= 1'b0;
        tx_q   <= 1'b1;
      end else begin
        tx_q    <= shreg[0];
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy_q && wr)
      shreg <= {1'b1, data};
    else if (busy_q && bit_end)
      shreg <= {1'b1, shreg[8:1]};  // lsb goes out first
  end

  a_idle_high: assert property (@(posedge clk) disable iff (!rst)
    !busy |-> tx)
    else $error("tx low while the transmitter is idle");

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

top=soc_mem_mmio_tb
log=sim.log

verilator --binary --timing --assert --top-module "$top" \
  -f soc_mem_mmio_top.f -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with no errors" "$log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: soc_mem_mmio_top.f
hw/mem_mmio_pkg.sv
hw/uart_tx_lite.sv
hw/axi_word_ram.sv
hw/mmio_ctrl.sv
hw/soc_mem_mmio_top.sv
verif/soc_mem_mmio_tb.sv

// File: verif/soc_mem_mmio_tb.sv
`timescale 1ns/1ps

module soc_mem_mmio_tb;
  import mem_mmio_pkg::*;

  localparam int idx_w     = ram_addr_w - 2;
  localparam int pool_sz   = 32;
  localparam int rand_ops  = 160;
  localparam int num_print = 4;
  localparam int num_ops   = pool_sz + rand_ops + 2 + 3 + 3 * num_print;

  logic clk = 1'b0;
  logic rst;
  logic [addr_w-1:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [data_w-1:0] wdata, rdata;
  logic [data_w/8-1:0] wstrb;
  logic [1:0] bresp, rresp;
  logic [7:0] csr;
  logic uart_tx;

  logic [31:0] lfsr_state = 32'h4c430328;
  logic [idx_w-1:0] pool [pool_sz];   // word indices that the random phase reuses
  logic [data_w-1:0] ram_model [int];
  logic [7:0] uart_exp [$];
  logic [7:0] csr_exp;
  bit stall_en;

  soc_mem_mmio_top dut (.*);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // random numbers and model helpers
  ////////////////////////////////////////////////////////////
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = b ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    return b;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[30:0], lfsr_bit()};
    return r;
  endfunction

  // random upper bits make the address alias onto the same ram word
  function automatic logic [addr_w-1:0] alias_addr(input logic [idx_w-1:0] idx);
    logic [31:0] r;
    r = lfsr_bits(addr_w - ram_addr_w - 1);
    return {1'b0, r[addr_w-ram_addr_w-2:0], idx, 2'b00};  // bit 31 clear stays off the mmio map
  endfunction

  function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_word,
      input logic [data_w-1:0] new_word, input logic [data_w/8-1:0] strb);
    logic [data_w-1:0] res;
    res = old_word;
    for (int b = 0; b < data_w/8; b++)
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_rdata(input logic [data_w-1:0] got, input logic [data_w-1:0] exp);
    if (got !== exp) begin
      $display("ERROR rdata: got 0x%h, expected 0x%h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_csr(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERROR csr: got 0x%h, expected 0x%h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_uart_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERROR uart_tx byte: got 0x%h, expected 0x%h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus tasks sample the outputs 1 ns after the falling edge
  ////////////////////////////////////////////////////////////
  task automatic axi_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
      input logic [data_w/8-1:0] strb);
    bit aw_done, w_done, seen, done;
    @(negedge clk);
    awaddr = addr;
    awvalid = 1'b1;
    wdata = data;
    wstrb = strb;
    wvalid = 1'b1;
    aw_done = 0;
    w_done = 0;
    while (!(aw_done && w_done)) begin
      #1;
      if (awvalid && awready) aw_done = 1;
      if (wvalid && wready) w_done = 1;
      @(negedge clk);
      if (aw_done) awvalid = 1'b0;
      if (w_done) wvalid = 1'b0;
    end
    seen = 0;
    done = 0;
    while (!done) begin
      bready = stall_en ? lfsr_bit() : 1'b1;
      #1;
      if (seen && !bvalid) begin
        $display("bvalid went low before the response was accepted");
        abort_run();
      end
      seen = seen || bvalid;
      if (bvalid && bready) begin
        check_resp("bresp", bresp, resp_okay);
        done = 1;
      end
      @(negedge clk);
    end
    bready = 1'b0;
    #1;
    check_flag("bvalid", bvalid, 1'b0);  // one request, one response
  endtask

  task automatic axi_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
    bit seen, done;
    logic [data_w-1:0] first;
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    done = 0;
    while (!done) begin
      #1;
      done = arready;
      @(negedge clk);
    end
    arvalid = 1'b0;
    seen = 0;
    done = 0;
    first = '0;
    while (!done) begin
      rready = stall_en ? lfsr_bit() : 1'b1;
      #1;
      if (seen && !rvalid) begin
        $display("rvalid went low before the read data was accepted");
        abort_run();
      end
      if (seen) check_rdata(rdata, first);  // held while rready is low
      if (rvalid && !seen) first = rdata;
      seen = seen || rvalid;
      if (rvalid && rready) begin
        check_resp("rresp", rresp, resp_okay);
        data = rdata;
        done = 1;
      end
      @(negedge clk);
    end
    rready = 1'b0;
    #1;
    check_flag("rvalid", rvalid, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // the uart monitor samples each bit near its middle
  ////////////////////////////////////////////////////////////
  initial begin : uart_monitor
    logic [7:0] got;
    wait (rst === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (clocks_per_baud / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        $display("uart start bit ended too early");
        abort_run();
      end
      for (int i = 0; i < 8; i++) begin
        repeat (clocks_per_baud) @(negedge clk);
        got[i] = uart_tx;  // lsb first
      end
      repeat (clocks_per_baud) @(negedge clk);
      if (uart_tx !== 1'b1) begin
        $display("uart stop bit is missing");
        abort_run();
      end
      if (uart_exp.size() == 0) begin
        $display("uart sent a frame with no print write behind it");
        abort_run();
      end else begin
        check_uart_byte(got, uart_exp.pop_front());
      end
    end
  end

  initial begin : watchdog
    repeat (num_ops * (12 * clocks_per_baud + 20)) @(posedge clk);
    $display("timeout, the tests did not finish in time");
    abort_run();
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_test
    logic [31:0] r;
    logic [data_w-1:0] data, got;
    logic [idx_w-1:0] idx;
    rst = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    csr_exp = 8'h00;
    stall_en = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    #1;
    check_csr(csr, csr_exp);
    check_flag("uart_tx", uart_tx, 1'b1);
    check_flag("bvalid", bvalid, 1'b0);
    check_flag("rvalid", rvalid, 1'b0);

    for (int i = 0; i < pool_sz; i++) begin  // full words first so no byte is unknown
      r = lfsr_bits(idx_w);
      pool[i] = r[idx_w-1:0];
      data = lfsr_bits(data_w);
      axi_write(alias_addr(pool[i]), data, '1);
      ram_model[int'(pool[i])] = data;
    end

    repeat (rand_ops) begin
      r = lfsr_bits(5);
      idx = pool[r[4:0]];
      if (lfsr_bit()) begin
        data = lfsr_bits(data_w);
        r = lfsr_bits(data_w / 8);
        axi_write(alias_addr(idx), data, r[data_w/8-1:0]);
        ram_model[int'(idx)] = merge_bytes(ram_model[int'(idx)], data, r[data_w/8-1:0]);
      end else begin
        axi_read(alias_addr(idx), got);
        check_rdata(got, ram_model[int'(idx)]);
      end
    end

    // an address 4 KiB above word 4 lands on word 4 again
    data = lfsr_bits(data_w);
    axi_write(32'h0000_0010, data, '1);
    ram_model[4] = data;
    axi_read(32'h0000_1010, got);
    check_rdata(got, ram_model[4]);

    // the csr write must not reach the ram word sharing its low bits
    data = lfsr_bits(data_w);
    axi_write(32'h0000_0008, data, '1);
    ram_model[2] = data;
    data = lfsr_bits(data_w);
    axi_write(mmio_csr_addr, data, '1);
    csr_exp = data[7:0];
    check_csr(csr, csr_exp);
    axi_read(32'h0000_0008, got);
    check_rdata(got, ram_model[2]);

    stall_en = 1'b0;
    for (int p = 0; p < num_print; p++) begin
      data = lfsr_bits(data_w);
      uart_exp.push_back(data[7:0]);
      axi_write(mmio_print_addr, data, '1);
      axi_read(mmio_status_addr, got);
      check_rdata(got, 32'h0000_0001);
      repeat (12 * clocks_per_baud) @(negedge clk);  // let the frame finish
      axi_read(mmio_status_addr, got);
      check_rdata(got, 32'h0000_0000);
    end
    check_csr(csr, csr_exp);

    if (uart_exp.size() != 0) begin
      $display("%0d uart frames never arrived", uart_exp.size());
      abort_run();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule
